// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int unsigned XLEN   = 32;
  localparam int unsigned REG_AW = 5;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000;  // also sub
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub

  typedef enum logic [3:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_JAL
  } br_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  localparam logic [31:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

  // fetched word as presented by the fetch side
  typedef struct packed {
    logic                            valid;
    logic [rv_isa_pkg::XLEN-1:0]     pc;
    rv_isa_pkg::inst_u               inst;
  } fetch_t;

  typedef struct packed {
    logic                            valid;
    logic [rv_isa_pkg::XLEN-1:0]     pc;
    logic [rv_isa_pkg::XLEN-1:0]     rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]     rs2_data;
    logic [rv_isa_pkg::XLEN-1:0]     imm;
    logic [rv_isa_pkg::REG_AW-1:0]   rd;
    logic                            rd_wen;
    rv_isa_pkg::alu_op_e             alu_op;
    rv_isa_pkg::br_op_e              br_op;
    logic                            use_imm;  // b operand from imm
  } id_ex_t;

  localparam id_ex_t ID_EX_BUBBLE = '{
    alu_op:  rv_isa_pkg::ALU_NONE,
    br_op:   rv_isa_pkg::BR_NONE,
    default: '0
  };

  typedef struct packed {
    logic id;
    logic ex;
  } stall_t;

  typedef struct packed {
    logic                            valid;
    logic [rv_isa_pkg::XLEN-1:0]     pc;
    logic [rv_isa_pkg::REG_AW-1:0]   rd;
    logic [rv_isa_pkg::XLEN-1:0]     value;
  } retire_t;

  typedef struct packed {
    logic                            valid;
    logic [rv_isa_pkg::XLEN-1:0]     target;
  } redirect_t;

endpackage

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  pipe_pkg::fetch_t                fetch_i,
  output logic [rv_isa_pkg::REG_AW-1:0]   rs1_idx_o,
  output logic [rv_isa_pkg::REG_AW-1:0]   rs2_idx_o,
  output logic                            rs1_used_o,
  output logic                            rs2_used_o,
  input  logic [rv_isa_pkg::XLEN-1:0]     rs1_data_i,
  input  logic [rv_isa_pkg::XLEN-1:0]     rs2_data_i,
  output pipe_pkg::id_ex_t                dec_o
);

  rv_isa_pkg::inst_u               inst;
  logic [rv_isa_pkg::XLEN-1:0]     imm_i;
  logic [rv_isa_pkg::XLEN-1:0]     imm_b;
  logic [rv_isa_pkg::XLEN-1:0]     imm_u;
  logic [rv_isa_pkg::XLEN-1:0]     imm_j;
  logic                            f7_ok;

  assign inst = fetch_i.inst;

  assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                  inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm31_12, 12'b0};
  assign imm_j = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                  inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

  // only sub takes the alternate funct7
  assign f7_ok = (inst.r_fmt.funct7 == rv_isa_pkg::F7_BASE) ||
                 (inst.r_fmt.funct7 == rv_isa_pkg::F7_ALT &&
                  inst.r_fmt.funct3 == rv_isa_pkg::F3_ADD);

  assign rs1_idx_o = inst.r_fmt.rs1;
  assign rs2_idx_o = inst.r_fmt.rs2;

  always_comb begin
    dec_o.valid    = fetch_i.valid;
    dec_o.pc       = fetch_i.pc;
    dec_o.rs1_data = rs1_data_i;
    dec_o.rs2_data = rs2_data_i;
    dec_o.imm      = '0;
    dec_o.rd       = inst.r_fmt.rd;
    dec_o.alu_op   = rv_isa_pkg::ALU_NONE;
    dec_o.br_op    = rv_isa_pkg::BR_NONE;
    dec_o.use_imm  = 1'b0;
    rs1_used_o     = 1'b0;
    rs2_used_o     = 1'b0;

    case (inst.r_fmt.opcode)
      rv_isa_pkg::OPC_OP: begin
        rs1_used_o = 1'b1;
        rs2_used_o = 1'b1;
        if (f7_ok) begin
          case (inst.r_fmt.funct3)
            rv_isa_pkg::F3_ADD: dec_o.alu_op = inst.r_fmt.funct7[5] ? rv_isa_pkg::ALU_SUB
                                                                    : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL: dec_o.alu_op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT: dec_o.alu_op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_XOR: dec_o.alu_op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL: dec_o.alu_op = rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:  dec_o.alu_op = rv_isa_pkg::ALU_OR;
            rv_isa_pkg::F3_AND: dec_o.alu_op = rv_isa_pkg::ALU_AND;
            default:            dec_o.alu_op = rv_isa_pkg::ALU_NONE;
          endcase
        end
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        rs1_used_o    = 1'b1;
        dec_o.imm     = imm_i;
        dec_o.use_imm = 1'b1;
        case (inst.i_fmt.funct3)  // no immediate shifts
          rv_isa_pkg::F3_ADD: dec_o.alu_op = rv_isa_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLT: dec_o.alu_op = rv_isa_pkg::ALU_SLT;
          rv_isa_pkg::F3_XOR: dec_o.alu_op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:  dec_o.alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_AND: dec_o.alu_op = rv_isa_pkg::ALU_AND;
          default:            dec_o.alu_op = rv_isa_pkg::ALU_NONE;
        endcase
      end
      rv_isa_pkg::OPC_LUI: begin
        dec_o.imm     = imm_u;
        dec_o.use_imm = 1'b1;
        dec_o.alu_op  = rv_isa_pkg::ALU_PASS_B;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        rs1_used_o = 1'b1;
        rs2_used_o = 1'b1;
        dec_o.imm  = imm_b;
        case (inst.b_fmt.funct3)
          rv_isa_pkg::F3_BEQ: dec_o.br_op = rv_isa_pkg::BR_EQ;
          rv_isa_pkg::F3_BNE: dec_o.br_op = rv_isa_pkg::BR_NE;
          default:            dec_o.br_op = rv_isa_pkg::BR_NONE;
        endcase
      end
      rv_isa_pkg::OPC_JAL: begin
        dec_o.imm   = imm_j;
        dec_o.br_op = rv_isa_pkg::BR_JAL;
      end
      default: ;  // unknown word, no-op
    endcase

    // jal writes the link, alu forms write their result
    dec_o.rd_wen = fetch_i.valid &&
                   (dec_o.alu_op != rv_isa_pkg::ALU_NONE || dec_o.br_op == rv_isa_pkg::BR_JAL);
    rs1_used_o   = rs1_used_o & fetch_i.valid;
    rs2_used_o   = rs2_used_o & fetch_i.valid;
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic [rv_isa_pkg::REG_AW-1:0]   rs1_idx_i,
  input  logic [rv_isa_pkg::REG_AW-1:0]   rs2_idx_i,
  output logic [rv_isa_pkg::XLEN-1:0]     rs1_data_o,
  output logic [rv_isa_pkg::XLEN-1:0]     rs2_data_o,
  input  pipe_pkg::retire_t               wr_i
);

  logic [rv_isa_pkg::XLEN-1:0] regs_q [32];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.valid && wr_i.rd != '0) begin
      regs_q[wr_i.rd] <= wr_i.value;
    end
  end

  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

  a_write_lands: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wr_i.valid && wr_i.rd != '0) |=> regs_q[$past(wr_i.rd)] == $past(wr_i.value));

endmodule

// ==== source/hazard_ctrl.sv ====
`timescale 1ns/1ps

module hazard_ctrl (
  input  logic [rv_isa_pkg::REG_AW-1:0]   rs1_idx_i,
  input  logic [rv_isa_pkg::REG_AW-1:0]   rs2_idx_i,
  input  logic                            rs1_used_i,
  input  logic                            rs2_used_i,
  input  logic [rv_isa_pkg::REG_AW-1:0]   ex_rd_i,
  input  logic                            ex_rd_wen_i,
  input  logic                            hold_i,
  input  pipe_pkg::redirect_t             redirect_i,
  output pipe_pkg::stall_t                stall_o,
  output logic                            flush_o
);

  logic raw;

  assign raw = ex_rd_wen_i && (ex_rd_i != '0) &&
               ((rs1_used_i && rs1_idx_i == ex_rd_i) ||
                (rs2_used_i && rs2_idx_i == ex_rd_i));

  // a redirect kills the decoding word, so no interlock for it
  assign stall_o.id = hold_i | (raw & ~redirect_i.valid);
  assign stall_o.ex = hold_i;
  assign flush_o    = redirect_i.valid & ~hold_i;  // held redirect stays in ex

endmodule

// ==== source/id_ex.sv ====
`timescale 1ns/1ps

module id_ex (
  input  logic              clk,
  input  logic              rst_n_i,
  input  pipe_pkg::stall_t  stall_i,
  input  logic              flush_i,
  input  pipe_pkg::id_ex_t  dec_i,
  output pipe_pkg::id_ex_t  ex_o
);

  logic              load_hazed;
  logic              reg_wen;
  logic              kill;
  pipe_pkg::id_ex_t  ex_d;
  pipe_pkg::id_ex_t  ex_q;

  // decode held but ex free, ex gets a bubble
  assign load_hazed = stall_i.id & ~stall_i.ex;
  assign reg_wen    = load_hazed | flush_i | ~stall_i.ex;
  assign kill       = load_hazed | flush_i;

  assign ex_d = kill ? pipe_pkg::ID_EX_BUBBLE : dec_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_q <= pipe_pkg::ID_EX_BUBBLE;
    end else if (reg_wen) begin
      ex_q <= ex_d;
    end
  end

  assign ex_o = ex_q;

  a_ex_frozen: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_i.ex |=> $stable(ex_o));

endmodule

// ==== source/ex_unit.sv ====
`timescale 1ns/1ps

module ex_unit (
  input  pipe_pkg::id_ex_t     ex_i,
  input  logic                 hold_i,
  output pipe_pkg::retire_t    retire_o,
  output pipe_pkg::retire_t    rf_wr_o,
  output pipe_pkg::redirect_t  redirect_o
);

  logic [rv_isa_pkg::XLEN-1:0] op_a;
  logic [rv_isa_pkg::XLEN-1:0] op_b;
  logic [rv_isa_pkg::XLEN-1:0] alu_res;
  logic [rv_isa_pkg::XLEN-1:0] link;
  logic [4:0]                  shamt;
  logic                        lt;
  logic                        taken;

  assign op_a  = ex_i.rs1_data;
  assign op_b  = ex_i.use_imm ? ex_i.imm : ex_i.rs2_data;
  assign shamt = op_b[4:0];
  assign lt    = $signed(op_a) < $signed(op_b);
  assign link  = ex_i.pc + 32'd4;

  always_comb begin
    case (ex_i.alu_op)
      rv_isa_pkg::ALU_ADD:    alu_res = op_a + op_b;
      rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_isa_pkg::ALU_SLT:    alu_res = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt};
      rv_isa_pkg::ALU_SLL:    alu_res = op_a << shamt;
      rv_isa_pkg::ALU_SRL:    alu_res = op_a >> shamt;
      rv_isa_pkg::ALU_PASS_B: alu_res = op_b;  // lui
      default:                alu_res = '0;
    endcase
  end

  // branches compare the raw register values
  always_comb begin
    case (ex_i.br_op)
      rv_isa_pkg::BR_EQ:  taken = (ex_i.rs1_data == ex_i.rs2_data);
      rv_isa_pkg::BR_NE:  taken = (ex_i.rs1_data != ex_i.rs2_data);
      rv_isa_pkg::BR_JAL: taken = 1'b1;
      default:            taken = 1'b0;
    endcase
  end

  assign retire_o.valid = ex_i.valid & ex_i.rd_wen;
  assign retire_o.pc    = ex_i.pc;
  assign retire_o.rd    = ex_i.rd;
  assign retire_o.value = (ex_i.br_op == rv_isa_pkg::BR_JAL) ? link : alu_res;

  // register write only lands once the item is consumed
  always_comb begin
    rf_wr_o       = retire_o;
    rf_wr_o.valid = retire_o.valid & ~hold_i;
  end

  assign redirect_o.valid  = ex_i.valid & taken;
  assign redirect_o.target = ex_i.pc + ex_i.imm;

endmodule

// ==== source/exu_core.sv ====
`timescale 1ns/1ps

module exu_core (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  pipe_pkg::fetch_t     fetch_i,
  input  logic                 hold_i,
  output logic                 stall_o,
  output pipe_pkg::retire_t    retire_o,
  output pipe_pkg::redirect_t  redirect_o
);

  logic [rv_isa_pkg::REG_AW-1:0] rs1_idx;
  logic [rv_isa_pkg::REG_AW-1:0] rs2_idx;
  logic                          rs1_used;
  logic                          rs2_used;
  logic [rv_isa_pkg::XLEN-1:0]   rs1_data;
  logic [rv_isa_pkg::XLEN-1:0]   rs2_data;
  pipe_pkg::id_ex_t              dec;
  pipe_pkg::id_ex_t              ex;
  pipe_pkg::stall_t              stall;
  logic                          flush;
  pipe_pkg::retire_t             rf_wr;

  rv_decoder u_decoder (
    .fetch_i   (fetch_i),
    .rs1_idx_o (rs1_idx),
    .rs2_idx_o (rs2_idx),
    .rs1_used_o(rs1_used),
    .rs2_used_o(rs2_used),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .dec_o     (dec)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rs1_idx_i (rs1_idx),
    .rs2_idx_i (rs2_idx),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wr_i      (rf_wr)
  );

  hazard_ctrl u_hazard_ctrl (
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_used_i (rs1_used),
    .rs2_used_i (rs2_used),
    .ex_rd_i    (ex.rd),
    .ex_rd_wen_i(ex.rd_wen),
    .hold_i     (hold_i),
    .redirect_i (redirect_o),
    .stall_o    (stall),
    .flush_o    (flush)
  );

  id_ex u_id_ex (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .stall_i(stall),
    .flush_i(flush),
    .dec_i  (dec),
    .ex_o   (ex)
  );

  ex_unit u_ex_unit (
    .ex_i      (ex),
    .hold_i    (hold_i),
    .retire_o  (retire_o),
    .rf_wr_o   (rf_wr),
    .redirect_o(redirect_o)
  );

  assign stall_o = stall.id;  // fetch side keeps its word

endmodule

// ==== test/tb_exu_core.sv ====
`timescale 1ns/1ps

module tb_exu_core;

  localparam int N_INST     = 2000;
  localparam int MAX_CYCLES = N_INST * 4;  // worst mix needs about 3 cycles each

  typedef enum logic [4:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL,
    K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI, K_LUI, K_BEQ, K_JAL, K_BNE
  } kind_e;

  typedef struct packed {
    kind_e             kind;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [31:0]       imm;
    rv_isa_pkg::inst_u word;
  } minst_t;

  logic                clk;
  logic                rst_n_i;
  pipe_pkg::fetch_t    fetch_i;
  logic                hold_i;
  logic                stall_o;
  pipe_pkg::retire_t   retire_o;
  pipe_pkg::redirect_t redirect_o;

  logic [31:0] lfsr_q = 32'h8e58;
  logic [31:0] model_regs [32];
  int          err_retire = 0;
  int          err_redirect = 0;
  int          err_stall = 0;
  int          cycles = 0;

  exu_core i_dut (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .fetch_i   (fetch_i),
    .hold_i    (hold_i),
    .stall_o   (stall_o),
    .retire_o  (retire_o),
    .redirect_o(redirect_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic [2:0] f3_of(input kind_e k);
    case (k)
      K_AND, K_ANDI: return rv_isa_pkg::F3_AND;
      K_OR, K_ORI:   return rv_isa_pkg::F3_OR;
      K_XOR, K_XORI: return rv_isa_pkg::F3_XOR;
      K_SLT, K_SLTI: return rv_isa_pkg::F3_SLT;
      K_SLL:         return rv_isa_pkg::F3_SLL;
      K_SRL:         return rv_isa_pkg::F3_SRL;
      K_BNE:         return rv_isa_pkg::F3_BNE;
      default:       return rv_isa_pkg::F3_ADD;  // add, sub, addi, beq
    endcase
  endfunction

  function automatic minst_t gen_inst();
    minst_t      m;
    logic [31:0] r;
    m      = '0;
    m.kind = kind_e'(rand_bits(4));
    if (m.kind == K_BEQ && rand_bits(1) == 1) begin
      m.kind = K_BNE;
    end
    m.rd  = 5'(rand_bits(3));  // x0..x7 keeps hazards frequent
    m.rs1 = 5'(rand_bits(3));
    m.rs2 = 5'(rand_bits(3));
    r     = rand_bits(20);
    if (m.kind <= K_SRL) begin
      m.word.r_fmt = '{(m.kind == K_SUB) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE,
                       m.rs2, m.rs1, f3_of(m.kind), m.rd, rv_isa_pkg::OPC_OP};
    end else if (m.kind <= K_SLTI) begin
      m.imm        = {{20{r[11]}}, r[11:0]};
      m.word.i_fmt = '{r[11:0], m.rs1, f3_of(m.kind), m.rd, rv_isa_pkg::OPC_OP_IMM};
    end else if (m.kind == K_LUI) begin
      m.imm        = {r[19:0], 12'b0};
      m.word.u_fmt = '{r[19:0], m.rd, rv_isa_pkg::OPC_LUI};
    end else if (m.kind == K_JAL) begin
      m.imm        = {{27{r[4]}}, r[3:0], 1'b0};  // small even offset
      m.word.j_fmt = '{m.imm[20], m.imm[10:1], m.imm[11], m.imm[19:12], m.rd,
                       rv_isa_pkg::OPC_JAL};
    end else begin
      m.imm        = {{27{r[4]}}, r[3:0], 1'b0};
      m.word.b_fmt = '{m.imm[12], m.imm[10:5], m.rs2, m.rs1, f3_of(m.kind), m.imm[4:1],
                       m.imm[11], rv_isa_pkg::OPC_BRANCH};
    end
    return m;
  endfunction

  function automatic logic uses_rs2(input kind_e k);
    return k <= K_SRL || k == K_BEQ || k == K_BNE;
  endfunction

  function automatic logic uses_rs1(input kind_e k);
    return k != K_LUI && k != K_JAL;
  endfunction

  // architectural step, updates the model registers
  task automatic execute(input minst_t m, input logic [31:0] pc,
                         output pipe_pkg::retire_t ret, output pipe_pkg::redirect_t red);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    a = model_regs[m.rs1];
    b = uses_rs2(m.kind) ? model_regs[m.rs2] : m.imm;
    case (m.kind)
      K_ADD, K_ADDI: v = a + b;
      K_SUB:         v = a - b;
      K_AND, K_ANDI: v = a & b;
      K_OR, K_ORI:   v = a | b;
      K_XOR, K_XORI: v = a ^ b;
      K_SLT, K_SLTI: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_SLL:         v = a << b[4:0];
      K_SRL:         v = a >> b[4:0];
      K_JAL:         v = pc + 32'd4;  // link
      default:       v = m.imm;       // lui
    endcase
    ret.valid  = m.kind != K_BEQ && m.kind != K_BNE;
    ret.pc     = pc;
    ret.rd     = m.rd;
    ret.value  = v;
    red.valid  = (m.kind == K_JAL) || (m.kind == K_BEQ && a == b) || (m.kind == K_BNE && a != b);
    red.target = pc + m.imm;
    if (ret.valid && m.rd != 5'd0) begin
      model_regs[m.rd] = v;
    end
  endtask

  task automatic check_retire(input pipe_pkg::retire_t got, input pipe_pkg::retire_t exp);
    if (got.valid !== exp.valid ||
        (exp.valid && (got.pc !== exp.pc || got.rd !== exp.rd || got.value !== exp.value))) begin
      err_retire++;
      $display("[ERROR] %0t retire got %0b/%h/%0d/%h exp %0b/%h/%0d/%h", $time,
               got.valid, got.pc, got.rd, got.value, exp.valid, exp.pc, exp.rd, exp.value);
    end
  endtask

  task automatic check_redirect(input pipe_pkg::redirect_t got,
                                input pipe_pkg::redirect_t exp);
    if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target)) begin
      err_redirect++;
      $display("[ERROR] %0t redirect got %0b/%h exp %0b/%h", $time,
               got.valid, got.target, exp.valid, exp.target);
    end
  endtask

  task automatic check_stall(input logic got, input logic exp);
    if (got !== exp) begin
      err_stall++;
      $display("[ERROR] %0t stall_o got %0b exp %0b", $time, got, exp);
    end
  endtask

  initial begin
    minst_t              cur;
    logic [31:0]         cur_pc;
    pipe_pkg::retire_t   pend_ret;
    pipe_pkg::redirect_t pend_red;
    logic                pend;
    logic                red_now;
    logic                raw;
    logic                exp_stall;
    logic                prev_stall;
    int                  n_acc;
    fetch_i    = '0;
    hold_i     = 1'b0;
    rst_n_i    = 1'b0;
    pend       = 1'b0;
    pend_ret   = '0;
    pend_red   = '0;
    prev_stall = 1'b0;
    n_acc      = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    cur    = gen_inst();
    cur_pc = 32'h0000_0100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    while (n_acc < N_INST || pend) begin
      if (n_acc >= N_INST) begin  // drain the last item
        hold_i        = 1'b0;
        fetch_i.valid = 1'b0;
      end else begin
        hold_i = (rand_bits(3) == 0);
        if (!prev_stall) begin
          fetch_i.valid = (rand_bits(3) != 0);
        end
      end
      fetch_i.pc   = cur_pc;
      fetch_i.inst = cur.word;
      #1;
      red_now = pend && pend_red.valid;
      raw     = pend && pend_ret.valid && pend_ret.rd != 5'd0 && fetch_i.valid &&
                ((uses_rs1(cur.kind) && cur.rs1 == pend_ret.rd) ||
                 (uses_rs2(cur.kind) && cur.rs2 == pend_ret.rd));
      exp_stall = hold_i || (raw && !red_now);
      check_stall(stall_o, exp_stall);
      if (!hold_i) begin
        check_retire(retire_o, pend ? pend_ret : '0);
        check_redirect(redirect_o, pend ? pend_red : '0);
        pend = 1'b0;
        if (red_now) begin  // word in decode is dropped
          cur_pc = pend_red.target;
          cur    = gen_inst();
        end else if (fetch_i.valid && !exp_stall) begin
          execute(cur, cur_pc, pend_ret, pend_red);
          pend   = 1'b1;
          n_acc++;
          cur_pc = cur_pc + 32'd4;
          cur    = gen_inst();
        end
      end
      prev_stall = exp_stall;
      @(negedge clk);
    end
    $display("errors: retire=%0d redirect=%0d stall=%0d (%0d instructions, %0d cycles)",
             err_retire, err_redirect, err_stall, n_acc, cycles);
    if (err_retire + err_redirect + err_stall == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== exu_core.f ====
common/rv_isa_pkg.sv
common/pipe_pkg.sv
source/rv_decoder.sv
source/reg_file.sv
source/hazard_ctrl.sv
source/id_ex.sv
source/ex_unit.sv
source/exu_core.sv
test/tb_exu_core.sv

// ==== Makefile ====
SIM    := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := tb_exu_core
FLIST  := exu_core.f
OBJDIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)
